//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - icache_pkg.sv
      - icache_tag_store.sv
      - icache_data_store.sv
      - icache_ctrl.sv
      - icache_refill.sv
      - icache_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - icache_chk.sv
      - icache_tb.sv

//--- files.f
icache_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_refill.sv
icache_top.sv
tb_clk_gen.sv
icache_chk.sv
icache_tb.sv

//--- icache_chk.sv
`default_nettype none

module icache_chk
    import icache_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input logic  fetch_req,
    input logic  fetch_valid,
    input logic  miss_stall,
    input logic  wb_cyc,
    input logic  wb_stb,
    input logic  wb_we,
    input logic  wb_ack,
    input addr_t wb_adr
);

    logic err_seen = 1'b0;  // watched from the testbench

    task automatic flag_error(input string what);
        $error("%s", what);
        err_seen = 1'b1;
    endtask

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !fetch_valid && !miss_stall && !wb_cyc && !wb_stb)
        else flag_error("fetch or bus output active during reset");

    stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb |-> wb_cyc)
        else flag_error("wb_stb high outside a bus cycle");

    read_only: assert property (@(posedge clk) !wb_we)
        else flag_error("wb_we went high");

    // classic cycle holds strobe and address until ack
    stb_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else flag_error("strobe or address changed before ack");

    valid_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_valid |-> fetch_req)
        else flag_error("fetch_valid without fetch_req");

    no_valid_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
        !(fetch_valid && miss_stall))
        else flag_error("fetch_valid and miss_stall high together");

endmodule

bind icache_top icache_chk u_chk (.*);

`default_nettype wire

//--- icache_ctrl.sv
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    fetch_req,
    input  addr_t   fetch_addr,
    input  logic    flush,
    input  logic    hit,
    input  logic    hit_way,
    input  logic    way0_valid,
    input  logic    way1_valid,
    input  logic    lru_way,
    input  logic    refill_done,
    output logic    fetch_valid,
    output logic    miss_stall,
    output index_t  rd_index,
    output tag_t    cmp_tag,
    output offset_t offset,
    output logic    upd_lru,
    output logic    upd_way,
    output logic    fill_en,
    output logic    fill_way,
    output logic    inv_all,
    output logic    refill_start,
    output addr_t   refill_addr
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    addr_t       req_addr_q;   // request being served
    logic        victim_q;
    logic        flush_pend_q;
    logic        take_req;
    index_t      req_index;
    index_t      new_index;

    assign cmp_tag   = req_addr_q[addr_w-1 -: tag_w];
    assign req_index = req_addr_q[addr_w-tag_w-1 -: index_w];
    assign offset    = req_addr_q[addr_w-tag_w-index_w-1 -: offset_w];
    assign new_index = fetch_addr[addr_w-tag_w-1 -: index_w];

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (flush || flush_pend_q) begin
                    state_d = st_flush;  // flush goes ahead of a request
                end else if (fetch_req) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                state_d = hit ? st_idle : st_refill;
            end
            st_refill: begin
                if (refill_done) begin
                    state_d = st_fill;
                end
            end
            st_fill:  state_d = st_idle;  // idle re-reads the filled set
            st_flush: state_d = st_idle;
            default:  state_d = st_idle;
        endcase
    end

    assign take_req = (state_q == st_idle) && (state_d == st_lookup);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q      <= st_idle;
            flush_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_d == st_flush) begin
                flush_pend_q <= 1'b0;
            end else if (flush) begin
                flush_pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            req_addr_q <= fetch_addr;
        end
        if (refill_start) begin
            // invalid way first, then LRU
            if (!way0_valid) begin
                victim_q <= 1'b0;
            end else if (!way1_valid) begin
                victim_q <= 1'b1;
            end else begin
                victim_q <= lru_way;
            end
        end
    end

    // in idle the arrays are addressed straight from the fetch port
    assign rd_index = (state_q == st_idle) ? new_index : req_index;

    assign fetch_valid  = (state_q == st_lookup) && hit;
    assign miss_stall   = (state_q == st_refill) || (state_q == st_fill);
    assign upd_lru      = fetch_valid;
    assign upd_way      = hit_way;
    assign fill_en      = (state_q == st_fill);
    assign fill_way     = victim_q;
    assign inv_all      = (state_q == st_flush);
    assign refill_start = (state_q == st_lookup) && !hit;
    assign refill_addr  = {cmp_tag, req_index, {(addr_w-tag_w-index_w){1'b0}}};  // line base

endmodule

`default_nettype wire

//--- icache_data_store.sv
`default_nettype none

module icache_data_store
    import icache_pkg::*;
(
    input  logic    clk,
    input  index_t  rd_index,
    input  logic    sel_way,
    input  offset_t sel_offset,
    input  logic    fill_en,
    input  logic    fill_way,
    input  index_t  fill_index,
    input  line_t   fill_line,
    output word_t   rd_word
);

    line_t line0_mem [2**index_w];
    line_t line1_mem [2**index_w];
    line_t line0_rd;
    line_t line1_rd;
    line_t sel_line;

    always_ff @(posedge clk) begin
        if (fill_en && !fill_way) begin
            line0_mem[fill_index] <= fill_line;
        end
        if (fill_en && fill_way) begin
            line1_mem[fill_index] <= fill_line;
        end
        line0_rd <= line0_mem[rd_index];  // both ways read in parallel
        line1_rd <= line1_mem[rd_index];
    end

    // late select once the tag compare is known
    always_comb begin
        sel_line = sel_way ? line1_rd : line0_rd;
        rd_word  = sel_line[sel_offset*word_w +: word_w];
    end

endmodule

`default_nettype wire

//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    localparam int addr_w     = 32;  // fetch / memory byte address
    localparam int tag_w      = 20;
    localparam int index_w    = 8;   // 256 sets
    localparam int offset_w   = 2;   // word within a line
    localparam int word_w     = 32;
    localparam int line_w     = 128;
    localparam int line_words = 4;

    typedef logic [addr_w-1:0]   addr_t;
    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [index_w-1:0]  index_t;
    typedef logic [offset_w-1:0] offset_t;
    typedef logic [word_w-1:0]   word_t;
    typedef logic [line_w-1:0]   line_t;   // word 0 in the low bits

    // controller states
    typedef enum logic [2:0] {
        st_idle,    // sample request, read arrays
        st_lookup,  // compare tags, deliver on hit
        st_refill,  // line fetch from next level
        st_fill,    // write line and tag into victim way
        st_flush    // drop all valid bits
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- icache_refill.sv
`default_nettype none

module icache_refill
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  refill_start,
    input  addr_t                 refill_addr,
    input  logic                  wb_ack,
    input  word_t                 wb_dat_i,
    output logic                  refill_done,
    output line_t                 refill_line,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output addr_t                 wb_adr,
    output logic                  wb_we,
    output logic [word_w/8-1:0]   wb_sel
);

    logic    busy_q;   // line in progress
    logic    cyc_q;
    logic    done_q;
    offset_t beat_q;
    addr_t   base_q;
    line_t   line_q;
    logic    last_beat;
    logic    beat_ack;

    assign beat_ack  = cyc_q && wb_ack;
    assign last_beat = (beat_q == offset_t'(line_words - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            cyc_q  <= 1'b0;
            done_q <= 1'b0;
            beat_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (refill_start) begin
                busy_q <= 1'b1;
                cyc_q  <= 1'b1;
                beat_q <= '0;
            end else if (beat_ack) begin
                cyc_q <= 1'b0;  // cycle drops between beats
                if (last_beat) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    beat_q <= beat_q + 1'b1;
                end
            end else if (busy_q && !cyc_q) begin
                cyc_q <= 1'b1;  // next single read
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start) begin
            base_q <= refill_addr;
        end
        if (beat_ack) begin
            line_q <= {wb_dat_i, line_q[line_w-1:word_w]};  // word 0 ends up lowest
        end
    end

    assign wb_cyc      = cyc_q;
    assign wb_stb      = cyc_q;
    assign wb_adr      = base_q + (addr_t'(beat_q) << 2);  // word stride
    assign wb_we       = 1'b0;   // reads only
    assign wb_sel      = '1;
    assign refill_done = done_q;
    assign refill_line = line_q;  // held until the next refill

endmodule

`default_nettype wire

//--- icache_tag_store.sv
`default_nettype none

module icache_tag_store
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  index_t rd_index,
    input  tag_t   cmp_tag,
    input  logic   fill_en,
    input  logic   fill_way,
    input  tag_t   fill_tag,
    input  logic   upd_lru,
    input  logic   upd_way,
    input  logic   inv_all,
    output logic   hit,
    output logic   hit_way,
    output logic   way0_valid,
    output logic   way1_valid,
    output logic   lru_way
);

    tag_t               tag0_mem [2**index_w];
    tag_t               tag1_mem [2**index_w];
    logic [2**index_w-1:0] valid0_q;
    logic [2**index_w-1:0] valid1_q;
    logic [2**index_w-1:0] lru_q;     // way to replace next
    tag_t               tag0_rd;
    tag_t               tag1_rd;
    logic               hit0;
    logic               hit1;

    always_ff @(posedge clk) begin
        if (fill_en && !fill_way) begin
            tag0_mem[rd_index] <= fill_tag;
        end
        if (fill_en && fill_way) begin
            tag1_mem[rd_index] <= fill_tag;
        end
        tag0_rd <= tag0_mem[rd_index];  // registered read
        tag1_rd <= tag1_mem[rd_index];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid0_q <= '0;
            valid1_q <= '0;
            lru_q    <= '0;
        end else begin
            if (inv_all) begin
                valid0_q <= '0;
                valid1_q <= '0;
            end else if (fill_en) begin
                if (fill_way) begin
                    valid1_q[rd_index] <= 1'b1;
                end else begin
                    valid0_q[rd_index] <= 1'b1;
                end
            end
            if (fill_en) begin
                lru_q[rd_index] <= ~fill_way;  // point at the other way
            end else if (upd_lru) begin
                lru_q[rd_index] <= ~upd_way;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            way0_valid <= 1'b0;
            way1_valid <= 1'b0;
            lru_way    <= 1'b0;
        end else begin
            way0_valid <= valid0_q[rd_index];
            way1_valid <= valid1_q[rd_index];
            lru_way    <= lru_q[rd_index];
        end
    end

    assign hit0    = way0_valid && (tag0_rd == cmp_tag);
    assign hit1    = way1_valid && (tag1_rd == cmp_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = !hit0;  // way 0 wins if both match

endmodule

`default_nettype wire

//--- icache_tb.sv
`default_nettype none

module icache_tb
    import icache_pkg::*;
();

    logic                clk;
    logic                arst_n;
    logic                fetch_req;
    addr_t               fetch_addr;
    logic                flush;
    logic                fetch_valid;
    word_t               fetch_data;
    logic                miss_stall;
    logic                wb_cyc;
    logic                wb_stb;
    addr_t               wb_adr;
    logic                wb_we;
    logic [word_w/8-1:0] wb_sel;
    word_t               wb_dat_i = '0;
    logic                wb_ack   = 1'b0;

    integer seed;
    integer ack_seed;
    int     ack_wait = -1;      // -1 while no strobe is being served
    int     beat_cnt;
    addr_t  line_base;
    tag_t   model_tag   [2][2**index_w];
    logic   model_valid [2][2**index_w];
    logic   model_lru   [2**index_w];

    localparam addr_t line_a = 32'h0000_1230;  // three tags, same set
    localparam addr_t line_b = 32'h0004_1230;
    localparam addr_t line_c = 32'h0008_1230;

    tb_clk_gen u_clk_gen (
        .clk (clk)
    );

    icache_top u_dut (.*);

    function automatic word_t mem_word(input addr_t a);
        return a ^ 32'h5A5A_0000;  // next-level memory contents
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
            else stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    // reference cache picking invalid ways before the LRU way
    task automatic model_access(input addr_t a, output logic was_hit);
        tag_t   t;
        index_t i;
        logic   w;
        t       = a[31:12];
        i       = a[11:4];
        was_hit = 1'b1;
        if (model_valid[0][i] && model_tag[0][i] == t) begin
            w = 1'b0;
        end else if (model_valid[1][i] && model_tag[1][i] == t) begin
            w = 1'b1;
        end else begin
            was_hit = 1'b0;
            w       = !model_valid[0][i] ? 1'b0 : !model_valid[1][i] ? 1'b1 : model_lru[i];
            model_valid[w][i] = 1'b1;
            model_tag[w][i]   = t;
        end
        model_lru[i] = !w;
    endtask

    // single-read slave with 0 to 3 wait cycles
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_stb) begin
            if (ack_wait < 0) begin
                ack_wait = {$random(ack_seed)} % 4;
            end
            if (ack_wait == 0) begin
                check_value("wb_adr", line_base + (beat_cnt << 2), wb_adr);
                check_value("wb_we", 0, wb_we);
                check_value("wb_sel", 4'hf, wb_sel);
                wb_dat_i <= mem_word(wb_adr);
                wb_ack   <= 1'b1;
                beat_cnt = beat_cnt + 1;
                ack_wait = -1;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (u_dut.u_chk.err_seen) begin
            stop_run("bus or handshake checker reported an error");
        end
    end

    // starts and ends on a falling edge with the controller idle
    task automatic fetch(input addr_t a);
        logic exp_hit;
        logic stall_seen;
        int   cycles;
        model_access(a, exp_hit);
        line_base  = {a[31:4], 4'h0};
        beat_cnt   = 0;
        stall_seen = 1'b0;
        cycles     = 0;
        fetch_req  = 1'b1;
        fetch_addr = a;
        do begin
            @(negedge clk);
            cycles++;
            if (miss_stall) begin
                stall_seen = 1'b1;
            end
            if (exp_hit) begin
                check_value("wb_cyc", 0, wb_cyc);  // hits stay off the bus
            end
            if (cycles > 100) begin
                stop_run($sformatf("no fetch_valid within 100 cycles for address %h", a));
            end
        end while (!fetch_valid);
        check_value("fetch_data", mem_word(a), fetch_data);
        check_value("wb_ack count", exp_hit ? 0 : line_words, beat_cnt);
        if (exp_hit) begin
            check_value("fetch_valid latency", 1, cycles);
        end else begin
            assert (stall_seen)
                else stop_run($sformatf("miss at address %h never raised miss_stall", a));
        end
        @(negedge clk);  // request held through the valid cycle
        fetch_req = 1'b0;
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        @(negedge clk);  // st_flush over and back in idle
        for (int i = 0; i < 2**index_w; i++) begin
            model_valid[0][i] = 1'b0;
            model_valid[1][i] = 1'b0;
        end
    endtask

    initial begin
        int r_tag;
        int r_set;
        int r_word;
        seed       = 81456;
        ack_seed   = 81456;
        arst_n     = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        flush      = 1'b0;
        for (int i = 0; i < 2**index_w; i++) begin
            model_valid[0][i] = 1'b0;
            model_valid[1][i] = 1'b0;
            model_lru[i]      = 1'b0;
        end
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        fetch(line_a + 4);  // miss, then the rest of the line hits
        fetch(line_a);
        fetch(line_a + 8);
        fetch(line_a + 12);
        fetch(line_b);      // second way of the set
        fetch(line_a);
        fetch(line_b);
        fetch(line_a);      // b is now least recently used
        fetch(line_c);
        fetch(line_a);
        fetch(line_b);
        flush_cache();
        fetch(line_a);
        fetch(line_a + 4);
        repeat (200) begin
            if ({$random(seed)} % 16 == 0) begin
                flush_cache();
            end
            r_tag  = {$random(seed)} % 4;
            r_set  = {$random(seed)} % 2;
            r_word = {$random(seed)} % 4;
            fetch(addr_t'((r_tag << 12) | ((r_set + 'h23) << 4) | (r_word << 2)));
        end
        @(negedge clk);
        if (u_dut.u_chk.err_seen) begin
            stop_run("bus or handshake checker reported an error");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- icache_top.sv
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                fetch_req,
    input  addr_t               fetch_addr,
    input  logic                flush,
    output logic                fetch_valid,
    output word_t               fetch_data,
    output logic                miss_stall,
    output logic                wb_cyc,
    output logic                wb_stb,
    output addr_t               wb_adr,
    output logic                wb_we,
    output logic [word_w/8-1:0] wb_sel,
    input  word_t               wb_dat_i,
    input  logic                wb_ack
);

    index_t  rd_index;
    tag_t    cmp_tag;
    offset_t offset;
    logic    hit;
    logic    hit_way;
    logic    way0_valid;
    logic    way1_valid;
    logic    lru_way;
    logic    upd_lru;
    logic    upd_way;
    logic    fill_en;
    logic    fill_way;
    logic    inv_all;
    logic    refill_start;
    addr_t   refill_addr;
    logic    refill_done;
    line_t   refill_line;

    icache_tag_store u_tag_store (
        .clk        (clk),
        .arst_n     (arst_n),
        .rd_index   (rd_index),
        .cmp_tag    (cmp_tag),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_tag   (cmp_tag),      // tag of the missed request
        .upd_lru    (upd_lru),
        .upd_way    (upd_way),
        .inv_all    (inv_all),
        .hit        (hit),
        .hit_way    (hit_way),
        .way0_valid (way0_valid),
        .way1_valid (way1_valid),
        .lru_way    (lru_way)
    );

    icache_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .flush        (flush),
        .hit          (hit),
        .hit_way      (hit_way),
        .way0_valid   (way0_valid),
        .way1_valid   (way1_valid),
        .lru_way      (lru_way),
        .refill_done  (refill_done),
        .fetch_valid  (fetch_valid),
        .miss_stall   (miss_stall),
        .rd_index     (rd_index),
        .cmp_tag      (cmp_tag),
        .offset       (offset),
        .upd_lru      (upd_lru),
        .upd_way      (upd_way),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .inv_all      (inv_all),
        .refill_start (refill_start),
        .refill_addr  (refill_addr)
    );

    icache_data_store u_data_store (
        .clk        (clk),
        .rd_index   (rd_index),
        .sel_way    (hit_way),
        .sel_offset (offset),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_index (rd_index),     // held on the request set during fill
        .fill_line  (refill_line),
        .rd_word    (fetch_data)
    );

    icache_refill u_refill (
        .clk          (clk),
        .arst_n       (arst_n),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .wb_ack       (wb_ack),
        .wb_dat_i     (wb_dat_i),
        .refill_done  (refill_done),
        .refill_line  (refill_line),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_we        (wb_we),
        .wb_sel       (wb_sel)
    );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;  // period of 100
        end
    end

endmodule

`default_nettype wire
